// ==== dcache_pkg.sv ====
/*
 Data cache package
 Cache geometry and backing memory constants
 Address, data, way and index typedefs
 Load/store, memory request and memory return structs
 Backing memory initial content rule
*/
package dcache_pkg;
    localparam int DCACHE_WAYS = 2;
    localparam int DCACHE_LINES = 16;          // Sets per way
    localparam int DCACHE_LINE_W = 4;          // Words per line
    localparam int MEM_WORDS = 1024;
    localparam int MEM_LATENCY = 3;            // Ack to first returned word

    localparam int DCACHE_SUB_LINE_ADDR_W = $clog2(DCACHE_LINE_W);
    localparam int DCACHE_LINE_ADDR_W = $clog2(DCACHE_LINES);
    localparam int DCACHE_TAG_W = 32 - DCACHE_LINE_ADDR_W - DCACHE_SUB_LINE_ADDR_W - 2;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);
    localparam int MEM_LAT_CNT_W = $clog2(MEM_LATENCY + 1);

    // Word i of memory starts as (i * MUL) ^ XOR
    localparam logic [31:0] MEM_INIT_MUL = 32'h9e37_79b9;
    localparam logic [31:0] MEM_INIT_XOR = 32'h5a5a_0f0f;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] be_t;
    typedef logic [DCACHE_WAYS-1:0] way_t;                  // One-hot
    typedef logic [$clog2(DCACHE_WAYS)-1:0] way_idx_t;
    typedef logic [DCACHE_LINE_ADDR_W-1:0] line_idx_t;
    typedef logic [DCACHE_SUB_LINE_ADDR_W-1:0] word_idx_t;
    typedef logic [DCACHE_TAG_W-1:0] tag_t;
    typedef logic [MEM_ADDR_W-1:0] mem_idx_t;

    typedef struct packed {
        addr_t addr;
        word_t data_in;
        be_t be;
        logic load;
        logic store;
    } ls_req_t;

    typedef struct packed {
        addr_t addr;          // Word aligned
        word_t data;
        be_t be;
        logic rnw;
        word_idx_t size;      // Words minus one
    } mem_req_t;

    typedef struct packed {
        word_t data;
        logic data_valid;
    } mem_resp_t;

    // Byte address split into cache fields
    typedef struct packed {
        tag_t tag;
        line_idx_t line;
        word_idx_t word;
        logic [1:0] byte_off;
    } addr_fields_t;

    typedef struct packed {
        way_idx_t way;
        line_idx_t line;
        word_idx_t word;
    } bank_addr_t;

    function automatic word_t mem_init_word(input int unsigned idx);
        return (word_t'(idx) * MEM_INIT_MUL) ^ MEM_INIT_XOR;
    endfunction
endpackage

// ==== dtag_banks.sv ====
/*
 Data cache tag banks
 Per-way tag array and valid bits
 Stage-1 tag read, stage-2 compare, line allocate on update
*/
`timescale 1ns/1ps

module dtag_banks (
    input logic clk,
    input logic rst,
    input logic stage1_adv,
    input dcache_pkg::addr_t stage1_addr,
    input dcache_pkg::addr_t stage2_addr,
    input logic update,
    input dcache_pkg::way_t update_way,
    output logic tag_hit,
    output dcache_pkg::way_t tag_hit_way
);
    dcache_pkg::addr_fields_t s1;
    dcache_pkg::addr_fields_t s2;

    assign s1 = stage1_addr;
    assign s2 = stage2_addr;

    for (genvar w = 0; w < dcache_pkg::DCACHE_WAYS; w++) begin : g_way
        dcache_pkg::tag_t tags [dcache_pkg::DCACHE_LINES];
        logic [dcache_pkg::DCACHE_LINES-1:0] valid;
        dcache_pkg::tag_t stored_tag;
        logic stored_valid;

        always_ff @(posedge clk) begin
            if (update & update_way[w])
                tags[s2.line] <= s2.tag;
            if (stage1_adv)
                stored_tag <= tags[s1.line];   // Read for next cycle compare
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                valid <= '0;
            end else if (update & update_way[w]) begin
                valid[s2.line] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst)
                stored_valid <= 1'b0;
            else if (stage1_adv)
                stored_valid <= valid[s1.line];
        end

        // Compare against the request now in stage 2
        assign tag_hit_way[w] = stored_valid & (stored_tag == s2.tag);
    end

    assign tag_hit = |tag_hit_way;
endmodule

// ==== ddata_bank.sv ====
/*
 Data cache data RAM
 Port A reads and byte-enabled writes, port B full-word refill writes
*/
`timescale 1ns/1ps

module ddata_bank (
    input logic clk,
    input dcache_pkg::bank_addr_t addr_a,
    input dcache_pkg::bank_addr_t addr_b,
    input logic en_a,
    input logic en_b,
    input dcache_pkg::be_t be_a,
    input dcache_pkg::word_t data_in_a,
    input dcache_pkg::word_t data_in_b,
    output dcache_pkg::word_t data_out_a
);
    dcache_pkg::word_t ram [dcache_pkg::DCACHE_WAYS * dcache_pkg::DCACHE_LINES *
                            dcache_pkg::DCACHE_LINE_W];

    always_ff @(posedge clk) begin
        if (en_a) begin
            data_out_a <= ram[addr_a];   // Old data on a write
            for (int i = 0; i < $bits(dcache_pkg::be_t); i++) begin
                if (be_a[i])
                    ram[addr_a][8*i +: 8] <= data_in_a[8*i +: 8];
            end
        end
        if (en_b)
            ram[addr_b] <= data_in_b;
    end
endmodule

// ==== dcache.sv ====
/*
 Two-way write-through data cache
 Stage-2 request register, hit/miss/store decision, memory requests
 Line refill, round-robin replacement, output mux, ready/idle tracking
*/
`timescale 1ns/1ps

module dcache (
    input logic clk,
    input logic rst,
    input logic dcache_on,
    input logic new_request,
    input dcache_pkg::ls_req_t ls_req,
    output logic ready,
    output logic data_valid,
    output dcache_pkg::word_t data_out,
    output logic mem_request,
    output dcache_pkg::mem_req_t mem_req,
    input logic mem_ack,
    input dcache_pkg::mem_resp_t mem_resp
);
    dcache_pkg::ls_req_t stage2;
    dcache_pkg::addr_fields_t s2;

    logic second_cycle;
    logic read_hit_allowed;
    logic read_hit_data_valid;
    logic read_hit;
    logic tag_update;
    logic request;
    logic idle;
    logic read_miss_complete;
    logic store_complete;
    logic line_complete;
    logic is_target_word;

    logic tag_hit;
    dcache_pkg::way_t tag_hit_way;
    dcache_pkg::way_idx_t tag_hit_way_int;
    dcache_pkg::way_t replacement_way;
    dcache_pkg::way_idx_t replacement_way_int;
    dcache_pkg::way_t tag_update_way;
    dcache_pkg::way_idx_t tag_update_way_int;

    dcache_pkg::word_idx_t word_count;
    dcache_pkg::be_t write_hit_be;
    dcache_pkg::word_t dbank_data_out;
    dcache_pkg::word_t miss_data;
    dcache_pkg::bank_addr_t bank_addr_a;
    dcache_pkg::bank_addr_t bank_addr_b;

    function automatic dcache_pkg::way_idx_t one_hot_to_int(input dcache_pkg::way_t one_hot);
        dcache_pkg::way_idx_t idx;
        idx = '0;
        for (int i = 0; i < dcache_pkg::DCACHE_WAYS; i++) begin
            if (one_hot[i])
                idx = idx | dcache_pkg::way_idx_t'(i);
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (new_request)
            stage2 <= ls_req;
    end
    assign s2 = stage2.addr;

    // Hit path control
    always_ff @(posedge clk) begin
        if (rst) begin
            second_cycle <= 1'b0;
            read_hit_allowed <= 1'b0;
            read_hit_data_valid <= 1'b0;
        end else begin
            second_cycle <= new_request;
            read_hit_allowed <= new_request & ls_req.load & dcache_on;
            read_hit_data_valid <= read_hit_allowed;
        end
    end
    assign read_hit = read_hit_allowed & tag_hit;

    always_ff @(posedge clk) begin
        if (rst)
            tag_update <= 1'b0;
        else
            tag_update <= second_cycle & dcache_on & stage2.load & ~tag_hit;  // Read miss
    end

    // Memory request, held until ack
    always_ff @(posedge clk) begin
        if (rst)
            request <= 1'b0;
        else if (second_cycle & ~mem_ack)
            request <= ~read_hit;
        else if (mem_ack)
            request <= 1'b0;
    end
    assign mem_request = request | (second_cycle & ~read_hit);

    assign mem_req = '{
        addr: {stage2.addr[31:2], 2'b00},
        data: stage2.data_in,
        be: stage2.be,
        rnw: stage2.load,
        size: stage2.load ? dcache_pkg::word_idx_t'(dcache_pkg::DCACHE_LINE_W - 1) : '0
    };

    // Refill word counter
    always_ff @(posedge clk) begin
        if (rst)
            word_count <= '0;
        else if (mem_resp.data_valid)
            word_count <= word_count + 1'b1;
    end
    assign is_target_word = (s2.word == word_count);

    // Free-running victim selection
    always_ff @(posedge clk) begin
        if (rst)
            replacement_way <= dcache_pkg::way_t'(1);
        else
            replacement_way <= {replacement_way[dcache_pkg::DCACHE_WAYS-2:0],
                                replacement_way[dcache_pkg::DCACHE_WAYS-1]};
    end
    assign replacement_way_int = one_hot_to_int(replacement_way);
    assign tag_hit_way_int = one_hot_to_int(tag_hit_way);

    always_ff @(posedge clk) begin
        if (second_cycle) begin
            tag_update_way <= replacement_way;
            tag_update_way_int <= replacement_way_int;
        end
    end

    dtag_banks tag_banks0 (
        .clk(clk),
        .rst(rst),
        .stage1_adv(new_request),
        .stage1_addr(ls_req.addr),
        .stage2_addr(stage2.addr),
        .update(tag_update),
        .update_way(tag_update_way),
        .tag_hit(tag_hit),
        .tag_hit_way(tag_hit_way)
    );

    // Store hits update the cached copy, also with the cache off
    assign write_hit_be = stage2.be & {$bits(dcache_pkg::be_t){tag_hit & stage2.store}};
    assign bank_addr_a = '{way: tag_hit_way_int, line: s2.line, word: s2.word};
    assign bank_addr_b = '{way: tag_update_way_int, line: s2.line, word: word_count};

    ddata_bank data_bank0 (
        .clk(clk),
        .addr_a(bank_addr_a),
        .addr_b(bank_addr_b),
        .en_a(second_cycle),
        .en_b(mem_resp.data_valid & dcache_on),   // No allocation while off
        .be_a(write_hit_be),
        .data_in_a(stage2.data_in),
        .data_in_b(mem_resp.data),
        .data_out_a(dbank_data_out)
    );

    // Miss word is zero outside its one cycle so it can be ORed with hit data
    always_ff @(posedge clk) begin
        if (mem_resp.data_valid & is_target_word)
            miss_data <= mem_resp.data;
        else
            miss_data <= '0;
    end
    assign data_out = miss_data |
                      ({$bits(dcache_pkg::word_t){read_hit_data_valid}} & dbank_data_out);

    assign line_complete = mem_resp.data_valid &
                           (word_count == dcache_pkg::word_idx_t'(dcache_pkg::DCACHE_LINE_W - 1));
    assign store_complete = mem_ack & stage2.store;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
            read_miss_complete <= 1'b0;
        end else begin
            data_valid <= (mem_resp.data_valid & is_target_word) | read_hit;
            read_miss_complete <= line_complete;
        end
    end

    assign ready = read_hit | store_complete | read_miss_complete | idle;

    always_ff @(posedge clk) begin
        if (rst)
            idle <= 1'b1;
        else if (new_request)
            idle <= 1'b0;
        else if (read_hit | read_miss_complete | store_complete)
            idle <= 1'b1;
    end
endmodule

// ==== backing_memory.sv ====
/*
 Behavioural backing memory
 Single-word byte-enabled writes at the ack
 Line-aligned read bursts after a fixed latency
*/
`timescale 1ns/1ps

module backing_memory (
    input logic clk,
    input logic rst,
    input logic mem_request,
    input dcache_pkg::mem_req_t mem_req,
    output logic mem_ack,
    output dcache_pkg::mem_resp_t mem_resp
);
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_BURST
    } mem_state_t;

    mem_state_t state;
    dcache_pkg::word_t mem [dcache_pkg::MEM_WORDS];
    dcache_pkg::mem_idx_t req_idx;
    dcache_pkg::mem_idx_t line_base;
    dcache_pkg::word_idx_t beat;
    dcache_pkg::word_idx_t burst_size;
    logic [dcache_pkg::MEM_LAT_CNT_W-1:0] lat_cnt;

    initial begin
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++)
            mem[i] = dcache_pkg::mem_init_word(i);
    end

    assign req_idx = mem_req.addr[dcache_pkg::MEM_ADDR_W+1:2];
    assign mem_ack = mem_request & (state == MEM_IDLE);

    always @(posedge clk) begin
        if (mem_ack & ~mem_req.rnw) begin
            for (int i = 0; i < $bits(dcache_pkg::be_t); i++) begin
                if (mem_req.be[i])
                    mem[req_idx][8*i +: 8] <= mem_req.data[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack) begin
            line_base <= req_idx & ~dcache_pkg::mem_idx_t'(dcache_pkg::DCACHE_LINE_W - 1);
            burst_size <= mem_req.size;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_IDLE;
            lat_cnt <= '0;
            beat <= '0;
        end else begin
            case (state)
                MEM_IDLE: if (mem_ack & mem_req.rnw) begin
                    state <= MEM_WAIT;
                    lat_cnt <= (dcache_pkg::MEM_LAT_CNT_W)'(dcache_pkg::MEM_LATENCY - 1);
                end
                MEM_WAIT: begin
                    if (lat_cnt == 1)
                        state <= MEM_BURST;
                    else
                        lat_cnt <= lat_cnt - 1'b1;
                end
                MEM_BURST: begin
                    beat <= beat + 1'b1;
                    if (beat == burst_size) begin   // Last word of the burst
                        state <= MEM_IDLE;
                        beat <= '0;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_comb begin
        mem_resp.data = mem[line_base | dcache_pkg::mem_idx_t'(beat)];
        mem_resp.data_valid = (state == MEM_BURST);
    end
endmodule

// ==== dcache_sys.sv ====
/*
 Data cache subsystem top
 Cache joined to the backing memory
*/
`timescale 1ns/1ps

module dcache_sys (
    input logic clk,
    input logic rst,
    input logic dcache_on,
    input logic new_request,
    input dcache_pkg::ls_req_t ls_req,
    output logic ready,
    output logic data_valid,
    output dcache_pkg::word_t data_out
);
    logic mem_request;
    logic mem_ack;
    dcache_pkg::mem_req_t mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    dcache dcache0 (
        .clk(clk),
        .rst(rst),
        .dcache_on(dcache_on),
        .new_request(new_request),
        .ls_req(ls_req),
        .ready(ready),
        .data_valid(data_valid),
        .data_out(data_out),
        .mem_request(mem_request),
        .mem_req(mem_req),
        .mem_ack(mem_ack),
        .mem_resp(mem_resp)
    );

    backing_memory mem0 (
        .clk(clk),
        .rst(rst),
        .mem_request(mem_request),
        .mem_req(mem_req),
        .mem_ack(mem_ack),
        .mem_resp(mem_resp)
    );
endmodule

// ==== tb_clock.sv ====
/*
 Testbench clock source
 Free-running clock with a 100 ns period
*/
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // Half of the 100 ns period
    end
endmodule

// ==== dcache_tb.sv ====
/*
 Testbench for the data cache subsystem
 Random loads and stores checked against a reference memory model
 Directed set-conflict and store/load sequences, cache-off phase
 Ready latency monitor, cycle timeout
*/
`timescale 1ns/1ps

module dcache_tb;
    localparam int PHASE_ON_OPS = 1500;
    localparam int PHASE_OFF_OPS = 1000;
    localparam int PHASE_REON_OPS = 1400;
    localparam int TOTAL_OPS = 4000;          // Upper bound over all phases
    localparam int CYCLES_PER_OP = 20;
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * CYCLES_PER_OP;
    // Ack in cycle 1, burst after the latency, ready after the last word
    localparam int MISS_READY_CYCLES = 1 + dcache_pkg::MEM_LATENCY + dcache_pkg::DCACHE_LINE_W;

    logic clk;
    logic rst;
    logic dcache_on;
    logic new_request;
    dcache_pkg::ls_req_t ls_req;
    logic ready;
    logic data_valid;
    dcache_pkg::word_t data_out;

    dcache_pkg::word_t model [dcache_pkg::MEM_WORDS];
    dcache_pkg::word_t expected_q [$];
    logic [31:0] rng_state;
    int loads_issued = 0;
    int valid_count = 0;
    int cycles = 0;
    logic req_pending;
    logic req_store;
    logic req_cache_on;
    int req_cycles;
    logic count_ok;

    tb_clock clock0 (.clk(clk));

    dcache_sys dut0 (
        .clk(clk),
        .rst(rst),
        .dcache_on(dcache_on),
        .new_request(new_request),
        .ls_req(ls_req),
        .ready(ready),
        .data_valid(data_valid),
        .data_out(data_out)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word in line, one of four sets, one of four tags, so sets overflow
    function automatic dcache_pkg::addr_t window_addr(input logic [31:0] r);
        return dcache_pkg::addr_t'({r[5:4], 2'b00, r[3:2], r[1:0], 2'b00});
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input dcache_pkg::word_t actual, input dcache_pkg::word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: load data %h, expected %h", $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_latency(input int actual, input int expected);
        if (actual != expected) begin
            $display("** Error at %0t: ready after %0d cycles, expected %0d",
                     $time, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_count(input int actual, input int expected, output logic ok);
        ok = (actual == expected);
        if (!ok)
            $display("** Error at %0t: %0d data_valid pulses for %0d loads",
                     $time, actual, expected);
    endtask

    // Issue one request once ready holds in a cycle with no strobe
    task automatic issue(input logic is_load, input dcache_pkg::addr_t addr,
                         input dcache_pkg::word_t data, input dcache_pkg::be_t be);
        dcache_pkg::ls_req_t req;
        dcache_pkg::mem_idx_t idx;
        @(negedge clk);
        while (!ready || new_request)
            @(negedge clk);
        req.addr = addr;
        req.data_in = data;
        req.be = be;
        req.load = is_load;
        req.store = !is_load;
        idx = addr[dcache_pkg::MEM_ADDR_W+1:2];
        if (is_load) begin
            expected_q.push_back(model[idx]);
            loads_issued++;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    model[idx][8*b +: 8] = data[8*b +: 8];   // Write-through merge
            end
        end
        @(posedge clk);
        new_request <= 1'b1;
        ls_req <= req;
        @(posedge clk);
        new_request <= 1'b0;
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] d;
        rng_state = xorshift(rng_state);
        r = rng_state;
        rng_state = xorshift(rng_state);
        d = rng_state;
        issue(r[7:6] != 2'b00, window_addr(r), d, r[11:8]);   // Three quarters loads
    endtask

    // Three lines in set 5 compete for two ways
    task automatic conflict_sweep();
        dcache_pkg::addr_t addr;
        for (int rep = 0; rep < 8; rep++) begin
            for (int t = 0; t < 3; t++) begin
                addr = dcache_pkg::addr_t'((t << 8) | (5 << 4) | ((rep % 4) << 2));
                issue(1'b1, addr, '0, '1);
            end
        end
    endtask

    // Even passes store to a loaded line, odd passes to a line never loaded
    task automatic store_load_pairs();
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t data;
        for (int n = 0; n < 8; n++) begin
            rng_state = xorshift(rng_state);
            addr = window_addr(rng_state);
            rng_state = xorshift(rng_state);
            data = rng_state;
            if (n % 2 == 0)
                issue(1'b1, addr, '0, '1);
            else
                addr = addr | 32'h0000_0c00;   // Tags 12 to 15 lie outside the random window
            issue(1'b0, addr, data, data[3:0]);
            issue(1'b1, addr, '0, '1);
        end
    endtask

    // Wait for idle, then past the cycle where a final hit returns its data
    task automatic drain();
        @(negedge clk);
        while (!ready || new_request)
            @(negedge clk);
        repeat (2) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (!rst && data_valid) begin
            valid_count++;
            if (expected_q.size() == 0) begin
                $display("data_valid pulsed at %0t with no load outstanding", $time);
                abort_run();
            end else begin
                check_word(data_out, expected_q.pop_front());
            end
        end
    end

    // Cycles from the strobe until ready rises again
    always @(negedge clk) begin
        int expected_cycles;
        if (rst) begin
            req_pending = 1'b0;
        end else if (new_request) begin
            req_pending = 1'b1;
            req_cycles = 0;
            req_store = ls_req.store;
            req_cache_on = dcache_on;
        end else if (req_pending) begin
            req_cycles++;
            if (ready) begin
                req_pending = 1'b0;
                if (req_store || (req_cache_on && req_cycles == 1))
                    expected_cycles = 1;   // Store ack or read hit
                else
                    expected_cycles = MISS_READY_CYCLES;
                check_latency(req_cycles, expected_cycles);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The run hung and did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        rst = 1'b1;
        dcache_on = 1'b1;
        new_request = 1'b0;
        ls_req = '0;
        rng_state = 32'd29;
        for (int i = 0; i < dcache_pkg::MEM_WORDS; i++)
            model[i] = (dcache_pkg::word_t'(i) * dcache_pkg::MEM_INIT_MUL) ^
                       dcache_pkg::MEM_INIT_XOR;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        conflict_sweep();
        store_load_pairs();
        repeat (PHASE_ON_OPS) random_op();
        drain();

        @(posedge clk);
        dcache_on <= 1'b0;   // Every access goes to memory
        store_load_pairs();
        repeat (PHASE_OFF_OPS) random_op();
        drain();

        @(posedge clk);
        dcache_on <= 1'b1;
        repeat (PHASE_REON_OPS) random_op();
        drain();

        check_count(valid_count, loads_issued, count_ok);
        if (count_ok) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run();
        end
    end
endmodule

// ==== files.f ====
dcache_pkg.sv
dtag_banks.sv
ddata_bank.sv
dcache.sv
backing_memory.sv
dcache_sys.sv
tb_clock.sv
dcache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module dcache_tb -f files.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "FAIL: see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0
